// ==== dcache_wr.f ====
+incdir+src
src/dcache_pkg.sv
src/req_slot.sv
src/mem_wrt_ctrl_d.sv
src/line_arbiter.sv
src/data_bank.sv
src/dcache_wr_top.sv
dv/dcache_wr_assert.sv
dv/dcache_wr_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dcache_wr.f --top-module dcache_wr_tb \
    -o sim_dcache_wr > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_dcache_wr +verilator+error+limit+1000 > sim.log 2>&1 \
    || { echo "simulation exited with an error, see sim.log"; exit 1; }

grep -q "Verification failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } \
    || { echo "PASS"; exit 0; }

// ==== dv/dcache_wr_vectors.txt ====
# refill/read: op, idx, then 16 hex words of the line from word 15 down to word 0
# store: op, addr, data, size, cacop, op flag, strobe; both adds refill idx and line
refill 1 1f1f1f1f 1e1e1e1e 1d1d1d1d 1c1c1c1c 1b1b1b1b 1a1a1a1a 19191919 18181818
         17171717 16161616 15151515 14141414 13131313 12121212 11111111 10101010
read 1 1f1f1f1f 1e1e1e1e 1d1d1d1d 1c1c1c1c 1b1b1b1b 1a1a1a1a 19191919 18181818
       17171717 16161616 15151515 14141414 13131313 12121212 11111111 10101010
store 00000049 000000ab 1 0 1 2
store 00000076 0000cdef 3 0 1 c
store 00000040 deadbeef f 0 1 f
idle
read 1 1f1f1f1f 1e1e1e1e cdef1d1d 1c1c1c1c 1b1b1b1b 1a1a1a1a 19191919 18181818
       17171717 16161616 15151515 14141414 13131313 1212ab12 11111111 deadbeef
refill 2 2f2f2f2f 2e2e2e2e 2d2d2d2d 2c2c2c2c 2b2b2b2b 2a2a2a2a 29292929 28282828
         27272727 26262626 25252525 24242424 23232323 22222222 21212121 20202020
store 00000083 00000077 1 0 0 f
store 00000085 00004455 3 1 1 3
store 0000008a 89abcdef f 0 1 c
store 000000bf 00000099 1 1 0 f
read 2 2f2f2f99 2e2e2e2e 2d2d2d2d 2c2c2c2c 2b2b2b2b 2a2a2a2a 29292929 28282828
       27272727 26262626 25252525 24242424 23232323 89ab2222 21214455 77202020
both 000000d4 00001234 3 0 1 3 3
       3f3f3f3f 3e3e3e3e 3d3d3d3d 3c3c3c3c 3b3b3b3b 3a3a3a3a 39393939 38383838
       37373737 36363636 35353535 34343434 33333333 32323232 31313131 30303030
read 3 3f3f3f3f 3e3e3e3e 3d3d3d3d 3c3c3c3c 3b3b3b3b 3a3a3a3a 39393939 38383838
       37373737 36363636 35351234 34343434 33333333 32323232 31313131 30303030
refill 6 6f6f6f6f 6e6e6e6e 6d6d6d6d 6c6c6c6c 6b6b6b6b 6a6a6a6a 69696969 68686868
         67676767 66666666 65656565 64646464 63636363 62626262 61616161 60606060
idle
both 000001a6 0000005a 1 0 1 4 4
       4f4f4f4f 4e4e4e4e 4d4d4d4d 4c4c4c4c 4b4b4b4b 4a4a4a4a 49494949 48484848
       47474747 46464646 45454545 44444444 43434343 42424242 41414141 40404040
refill 5 5f5f5f5f 5e5e5e5e 5d5d5d5d 5c5c5c5c 5b5b5b5b 5a5a5a5a 59595959 58585858
         57575757 56565656 55555555 54545454 53535353 52525252 51515151 50505050
read 4 4f4f4f4f 4e4e4e4e 4d4d4d4d 4c4c4c4c 4b4b4b4b 4a4a4a4a 49494949 48484848
       47474747 46464646 45454545 44444444 43434343 42424242 41414141 40404040
read 5 5f5f5f5f 5e5e5e5e 5d5d5d5d 5c5c5c5c 5b5b5b5b 5a5a5a5a 59595959 58585858
       57575757 56565656 55555555 54545454 53535353 52525252 51515151 50505050
read 6 6f6f6f6f 6e6e6e6e 6d6d6d6d 6c6c6c6c 6b6b6b6b 6a6a6a6a 695a6969 68686868
       67676767 66666666 65656565 64646464 63636363 62626262 61616161 60606060

// ==== dv/dcache_wr_tb.sv ====
`timescale 1ns/10ps

`include "dcache_wr_macros.svh"

module dcache_wr_tb;

    localparam int TIMEOUT = 200;
    localparam int WORDS   = `DCACHE_LINE_BITS / 32;

    logic                        clk;
    logic                        rst;
    logic                        store_valid;
    dcache_pkg::store_req_t      store_req;
    logic                        store_ready;
    logic                        refill_valid;
    dcache_pkg::refill_req_t     refill_req;
    logic                        refill_ready;
    logic                        rd_en;
    logic [`DCACHE_IDX_BITS-1:0] rd_idx;
    dcache_pkg::line_t           rd_line;
    dcache_pkg::strb_t           bus_strb;
    logic                        bus_strb_valid;

    int                line_errs  = 0;
    int                strb_errs  = 0;
    int                other_errs = 0;
    int                assert_errs;
    bit                hung       = 1'b0;
    logic              store_ready_q;
    dcache_pkg::strb_t exp_strb;
    dcache_pkg::strb_t strb_q[$];

    dcache_wr_top dut (
        .clk            (clk),
        .rst            (rst),
        .store_valid    (store_valid),
        .store_req      (store_req),
        .store_ready    (store_ready),
        .refill_valid   (refill_valid),
        .refill_req     (refill_req),
        .refill_ready   (refill_ready),
        .rd_en          (rd_en),
        .rd_idx         (rd_idx),
        .rd_line        (rd_line),
        .bus_strb       (bus_strb),
        .bus_strb_valid (bus_strb_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////

    task automatic check_line(input string name, input dcache_pkg::line_t got,
                              input dcache_pkg::line_t exp);
        if (got !== exp) begin
            line_errs++;
            $display("Error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_strb(input string name, input dcache_pkg::strb_t got,
                              input dcache_pkg::strb_t exp);
        if (got !== exp) begin
            strb_errs++;
            $display("Error %s: got %h expected %h", name, got, exp);
        end
    endtask

    // strobes leave in grant order; a store only leaves its slot by a grant.
    always @(negedge clk) begin
        if (!rst) begin
            if (store_ready && !store_ready_q && !bus_strb_valid) begin
                other_errs++;
                $display("store slot emptied without a bus strobe, a store was lost");
            end
            if (bus_strb_valid) begin
                if (strb_q.size() == 0) begin
                    other_errs++;
                    $display("bus_strb_valid pulsed with no store outstanding");
                end else begin
                    exp_strb = strb_q.pop_front();
                    check_strb("bus_strb", bus_strb, exp_strb);
                end
            end
        end
        store_ready_q = store_ready;
    end

    ////////////////////////////////////////////////////////////////////////
    // bounded waits
    ////////////////////////////////////////////////////////////////////////

    task automatic wait_ready(input bit need_st, input bit need_rf, input string what);
        int cycles;
        cycles = 0;
        while (!hung && ((need_st && !store_ready) || (need_rf && !refill_ready))) begin
            if (cycles == TIMEOUT) begin
                $display("timeout, %s not ready after %0d cycles", what, TIMEOUT);
                hung = 1'b1;
            end else begin
                @(posedge clk);
                #1;
                cycles++;
            end
        end
    endtask

    task automatic drain_strobes();
        int cycles;
        cycles = 0;
        while (!hung && strb_q.size() != 0) begin
            if (cycles == TIMEOUT) begin
                $display("timeout, %0d bus strobes never arrived", strb_q.size());
                hung = 1'b1;
            end else begin
                @(posedge clk);
                #1;
                cycles++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // request drivers
    ////////////////////////////////////////////////////////////////////////

    task automatic send_store(input dcache_pkg::store_req_t req, input dcache_pkg::strb_t strb);
        wait_ready(1'b1, 1'b0, "store port");
        if (hung) return;
        store_valid = 1'b1;
        store_req   = req;
        strb_q.push_back(strb);
        @(posedge clk);
        #1;
        store_valid = 1'b0;
    endtask

    task automatic send_refill(input dcache_pkg::refill_req_t req);
        wait_ready(1'b0, 1'b1, "refill port");
        if (hung) return;
        refill_valid = 1'b1;
        refill_req   = req;
        @(posedge clk);
        #1;
        refill_valid = 1'b0;
    endtask

    // store and refill in the same cycle; the store must wait behind the refill.
    task automatic send_both(input dcache_pkg::store_req_t st, input dcache_pkg::refill_req_t rf,
                             input dcache_pkg::strb_t strb);
        wait_ready(1'b1, 1'b1, "store and refill ports");
        if (hung) return;
        store_valid  = 1'b1;
        store_req    = st;
        refill_valid = 1'b1;
        refill_req   = rf;
        strb_q.push_back(strb);
        @(posedge clk);
        #1;
        store_valid  = 1'b0;
        refill_valid = 1'b0;
        // the refill takes this edge and the store stays held.
        @(posedge clk);
        #1;
        if (store_ready) begin
            other_errs++;
            $display("store_ready went high while a refill was ahead of the store");
        end
    endtask

    task automatic read_and_check(input logic [`DCACHE_IDX_BITS-1:0] idx,
                                  input dcache_pkg::line_t exp);
        // both slots empty, then one edge for the last bank write to land.
        wait_ready(1'b1, 1'b1, "write pipeline");
        if (hung) return;
        @(posedge clk);
        #1;
        rd_en  = 1'b1;
        rd_idx = idx;
        @(posedge clk);
        #1;
        rd_en = 1'b0;
        check_line($sformatf("rd_line (idx %h)", idx), rd_line, exp);
    endtask

    task automatic idle_gap();
        int n;
        n = $urandom_range(4, 1);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // vector file
    ////////////////////////////////////////////////////////////////////////

    // words are listed from word 15 down to word 0.
    task automatic read_line(input int fd, output dcache_pkg::line_t value);
        logic [31:0] word;
        int          rc;
        value = '0;
        for (int w = 0; w < WORDS; w++) begin
            rc = $fscanf(fd, "%h", word);
            if (rc != 1) begin
                other_errs++;
                $display("vector file ends in the middle of a line");
            end
            value = {value[`DCACHE_LINE_BITS-33:0], word};
        end
    endtask

    task automatic run_vectors();
        int                          fd;
        int                          rc;
        string                       op;
        string                       rest;
        logic [`DCACHE_IDX_BITS-1:0] idx;
        logic [31:0]                 addr;
        logic [31:0]                 data;
        logic [3:0]                  size;
        logic                        cacop;
        logic                        op_flag;
        dcache_pkg::strb_t           strb;
        dcache_pkg::line_t           line;
        dcache_pkg::store_req_t      st;
        dcache_pkg::refill_req_t     rf;
        fd = $fopen("dv/dcache_wr_vectors.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open dv/dcache_wr_vectors.txt");
            return;
        end
        while (!hung && $fscanf(fd, "%s", op) == 1) begin
            if (op == "#") begin
                rc = $fgets(rest, fd);
            end else if (op == "refill" || op == "read") begin
                rc = $fscanf(fd, "%h", idx);
                read_line(fd, line);
                if (op == "refill") begin
                    rf.idx  = idx;
                    rf.line = line;
                    send_refill(rf);
                end else begin
                    read_and_check(idx, line);
                end
            end else if (op == "store" || op == "both") begin
                rc = $fscanf(fd, "%h %h %h %h %h %h", addr, data, size, cacop, op_flag, strb);
                if (rc != 6) begin
                    other_errs++;
                    $display("store vector has %0d of 6 fields", rc);
                end
                st.addr     = addr;
                st.data     = data;
                st.wrt_type = dcache_pkg::wrt_type_e'(size);
                st.cacop    = cacop;
                st.op       = op_flag;
                if (op == "store") begin
                    send_store(st, strb);
                end else begin
                    rc = $fscanf(fd, "%h", idx);
                    read_line(fd, line);
                    rf.idx  = idx;
                    rf.line = line;
                    send_both(st, rf, strb);
                end
            end else if (op == "idle") begin
                idle_gap();
            end else begin
                other_errs++;
                $display("unknown opcode %s in the vector file", op);
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'h6915));
        rst          = 1'b1;
        store_valid  = 1'b0;
        store_req    = '0;
        refill_valid = 1'b0;
        refill_req   = '0;
        rd_en        = 1'b0;
        rd_idx       = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        run_vectors();
        drain_strobes();
        assert_errs = dut.u_arbiter.u_assert.fail_count;
        $display("errors: line %0d, strobe %0d, other %0d, assertion %0d",
                 line_errs, strb_errs, other_errs, assert_errs);
        if (hung || line_errs + strb_errs + other_errs + assert_errs != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

// ==== dv/dcache_wr_assert.sv ====
`timescale 1ns/10ps

module dcache_wr_assert (
    input logic                   clk,
    input logic                   rst,
    input logic                   st_full,
    input logic                   rf_full,
    input logic                   st_take,
    input logic                   rf_take,
    input dcache_pkg::store_req_t st_req
);

    int fail_count = 0;

    ////////////////////////////////////////////////////////////////////////
    // slot behavior seen by the arbiter
    ////////////////////////////////////////////////////////////////////////

    // a store passed over for a refill keeps its slot and its payload.
    a_st_hold: assert property (@(posedge clk) disable iff (rst)
        (st_full && !st_take) |=> (st_full && $stable(st_req)))
        else begin
            $error("held store changed or left its slot without a take");
            fail_count++;
        end

    ////////////////////////////////////////////////////////////////////////
    // take empties the slot
    ////////////////////////////////////////////////////////////////////////

    a_st_take_clears: assert property (@(posedge clk) disable iff (rst)
        st_take |=> !st_full)
        else begin
            $error("store slot still full one cycle after st_take");
            fail_count++;
        end

    a_rf_take_clears: assert property (@(posedge clk) disable iff (rst)
        rf_take |=> !rf_full)
        else begin
            $error("refill slot still full one cycle after rf_take");
            fail_count++;
        end

endmodule

bind line_arbiter dcache_wr_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .st_full (st_full),
    .rf_full (rf_full),
    .st_take (st_take),
    .rf_take (rf_take),
    .st_req  (st_req)
);

// ==== src/dcache_wr_top.sv ====
`timescale 1ns/10ps

`include "dcache_wr_macros.svh"

module dcache_wr_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        store_valid,
    input  dcache_pkg::store_req_t      store_req,
    output logic                        store_ready,
    input  logic                        refill_valid,
    input  dcache_pkg::refill_req_t     refill_req,
    output logic                        refill_ready,
    input  logic                        rd_en,
    input  logic [`DCACHE_IDX_BITS-1:0] rd_idx,
    output dcache_pkg::line_t           rd_line,
    output dcache_pkg::strb_t           bus_strb,
    output logic                        bus_strb_valid
);

    logic                    st_full;
    logic                    st_take;
    dcache_pkg::store_req_t  st_held;
    logic                    rf_full;
    logic                    rf_take;
    dcache_pkg::refill_req_t rf_held;
    dcache_pkg::bank_wr_t    bank_wr;
    logic                    wr_en;

    assign store_ready  = ~st_full;
    assign refill_ready = ~rf_full;

    ////////////////////////////////////////////////////////////////////////
    // request slots
    ////////////////////////////////////////////////////////////////////////

    req_slot #(.payload_t(dcache_pkg::store_req_t)) u_store_slot (
        .clk      (clk),
        .rst      (rst),
        .in_valid (store_valid),
        .in_data  (store_req),
        .take     (st_take),
        .full     (st_full),
        .out_data (st_held)
    );

    req_slot #(.payload_t(dcache_pkg::refill_req_t)) u_refill_slot (
        .clk      (clk),
        .rst      (rst),
        .in_valid (refill_valid),
        .in_data  (refill_req),
        .take     (rf_take),
        .full     (rf_full),
        .out_data (rf_held)
    );

    ////////////////////////////////////////////////////////////////////////
    // arbiter and bank
    ////////////////////////////////////////////////////////////////////////

    line_arbiter u_arbiter (
        .clk            (clk),
        .rst            (rst),
        .st_full        (st_full),
        .st_req         (st_held),
        .rf_full        (rf_full),
        .rf_req         (rf_held),
        .st_take        (st_take),
        .rf_take        (rf_take),
        .bank_wr        (bank_wr),
        .wr_en          (wr_en),
        .bus_strb       (bus_strb),
        .bus_strb_valid (bus_strb_valid)
    );

    data_bank u_bank (
        .clk     (clk),
        .wr_en   (wr_en),
        .bank_wr (bank_wr),
        .rd_en   (rd_en),
        .rd_idx  (rd_idx),
        .rd_line (rd_line)
    );

endmodule

// ==== src/data_bank.sv ====
`timescale 1ns/10ps

`include "dcache_wr_macros.svh"

module data_bank (
    input  logic                        clk,
    input  logic                        wr_en,
    input  dcache_pkg::bank_wr_t        bank_wr,
    input  logic                        rd_en,
    input  logic [`DCACHE_IDX_BITS-1:0] rd_idx,
    output dcache_pkg::line_t           rd_line
);

    localparam int NUM_BYTES = `DCACHE_LINE_BITS / 8;

    dcache_pkg::line_t mem [`DCACHE_DEPTH];

    ////////////////////////////////////////////////////////////////////////
    // byte-enabled write
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (bank_wr.we[b]) begin
                    mem[bank_wr.idx][b*8 +: 8] <= bank_wr.din[b*8 +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // line read
    ////////////////////////////////////////////////////////////////////////

    // old data is returned when read and write hit the same line.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_line <= mem[rd_idx];
        end
    end

endmodule

// ==== src/line_arbiter.sv ====
`timescale 1ns/10ps

`include "dcache_wr_macros.svh"

module line_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    st_full,
    input  dcache_pkg::store_req_t  st_req,
    input  logic                    rf_full,
    input  dcache_pkg::refill_req_t rf_req,
    output logic                    st_take,
    output logic                    rf_take,
    output dcache_pkg::bank_wr_t    bank_wr,
    output logic                    wr_en,
    output dcache_pkg::strb_t       bus_strb,
    output logic                    bus_strb_valid
);

    dcache_pkg::line_t    ctrl_din;
    dcache_pkg::we_mask_t ctrl_we;
    dcache_pkg::strb_t    ctrl_strb;
    dcache_pkg::bank_wr_t bank_wr_nxt;
    logic                 grant;

    ////////////////////////////////////////////////////////////////////////
    // fixed priority grant
    ////////////////////////////////////////////////////////////////////////

    // refill always wins.
    assign rf_take = rf_full;
    assign st_take = st_full & ~rf_full;
    assign grant   = st_take | rf_take;

    mem_wrt_ctrl_d u_wrt_ctrl (
        .w_data_cpu    (st_req.data),
        .w_data_axi    (rf_req.line),
        .addr_rbuf     (st_req.addr),
        .wrt_type      (st_req.wrt_type),
        .wrt_data_sel  (~rf_full),
        .cacop_en_rbuf (st_req.cacop),
        .op_rbuf       (st_req.op),
        .mem_din       (ctrl_din),
        .mem_we_normal (ctrl_we),
        .axi_we        (ctrl_strb)
    );

    always_comb begin
        bank_wr_nxt.din = ctrl_din;
        if (rf_full) begin
            bank_wr_nxt.idx = rf_req.idx;
            bank_wr_nxt.we  = '1;
        end else begin
            bank_wr_nxt.idx = st_req.addr[`DCACHE_IDX_BITS+5:6];
            bank_wr_nxt.we  = ctrl_we;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // registered bank write and bus strobe
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en          <= 1'b0;
            bus_strb_valid <= 1'b0;
        end else begin
            wr_en          <= grant;
            bus_strb_valid <= st_take;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            bank_wr <= bank_wr_nxt;
        end
        if (st_take) begin
            bus_strb <= ctrl_strb;
        end
    end

endmodule

// ==== src/mem_wrt_ctrl_d.sv ====
`timescale 1ns/10ps

`include "dcache_wr_macros.svh"

module mem_wrt_ctrl_d (
    input  logic [31:0]           w_data_cpu,
    input  dcache_pkg::line_t     w_data_axi,
    input  logic [31:0]           addr_rbuf,
    input  dcache_pkg::wrt_type_e wrt_type,
    input  logic                  wrt_data_sel,
    input  logic                  cacop_en_rbuf,
    input  logic                  op_rbuf,
    output dcache_pkg::line_t     mem_din,
    output dcache_pkg::we_mask_t  mem_we_normal,
    output dcache_pkg::strb_t     axi_we
);

    localparam int BYTES_PER_LINE = `DCACHE_LINE_BITS / 8;
    localparam int HALFS_PER_LINE = `DCACHE_LINE_BITS / 16;
    localparam int WORDS_PER_LINE = `DCACHE_LINE_BITS / 32;

    dcache_pkg::line_t store_din;
    dcache_pkg::strb_t lane_strb;
    logic [5:0]        mask_shift;

    ////////////////////////////////////////////////////////////////////////
    // write data
    ////////////////////////////////////////////////////////////////////////

    // store data is copied to every lane; the mask picks the real one.
    always_comb begin
        case (wrt_type)
            dcache_pkg::wrt_byte: store_din = {BYTES_PER_LINE{w_data_cpu[7:0]}};
            dcache_pkg::wrt_half: store_din = {HALFS_PER_LINE{w_data_cpu[15:0]}};
            dcache_pkg::wrt_word: store_din = {WORDS_PER_LINE{w_data_cpu}};
            default:              store_din = '0;
        endcase
    end

    assign mem_din = wrt_data_sel ? store_din : w_data_axi;

    ////////////////////////////////////////////////////////////////////////
    // byte strobe within the word
    ////////////////////////////////////////////////////////////////////////

    // cache ops use the size mask as is.
    always_comb begin
        if (cacop_en_rbuf) begin
            lane_strb = wrt_type;
        end else begin
            lane_strb = dcache_pkg::strb_t'(wrt_type << addr_rbuf[1:0]);
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // line byte-enable placement
    ////////////////////////////////////////////////////////////////////////

    // word offset times four bytes.
    assign mask_shift = {addr_rbuf[5:2], 2'b00};

    always_comb begin
        mem_we_normal = dcache_pkg::we_mask_t'(lane_strb) << mask_shift;
    end

    // non-op writes go out on the bus as full words.
    assign axi_we = op_rbuf ? lane_strb : 4'b1111;

endmodule

// ==== src/req_slot.sv ====
`timescale 1ns/10ps

module req_slot #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     take,
    output logic     full,
    output payload_t out_data
);

    logic load;

    // a strobe is only legal while the slot is empty.
    assign load = in_valid & ~full;

    ////////////////////////////////////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (load) begin
            full <= 1'b1;
        end else if (take) begin
            full <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // held payload
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== src/dcache_pkg.sv ====
`include "dcache_wr_macros.svh"

package dcache_pkg;

    ////////////////////////////////////////////////////////////////////////
    // line and mask types
    ////////////////////////////////////////////////////////////////////////

    typedef logic [`DCACHE_LINE_BITS-1:0] line_t;

    // one enable bit per byte of the line.
    typedef logic [`DCACHE_LINE_BITS/8-1:0] we_mask_t;

    typedef logic [3:0] strb_t;

    // store size, encoded as the byte mask of a word at offset 0.
    typedef enum logic [3:0] {
        wrt_byte = 4'b0001,
        wrt_half = 4'b0011,
        wrt_word = 4'b1111
    } wrt_type_e;

    ////////////////////////////////////////////////////////////////////////
    // requests
    ////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        wrt_type_e   wrt_type;
        logic        cacop;
        logic        op;
    } store_req_t;

    typedef struct packed {
        logic [`DCACHE_IDX_BITS-1:0] idx;
        line_t                       line;
    } refill_req_t;

    // one registered bank write.
    typedef struct packed {
        logic [`DCACHE_IDX_BITS-1:0] idx;
        line_t                       din;
        we_mask_t                    we;
    } bank_wr_t;

endpackage

// ==== src/dcache_wr_macros.svh ====
`ifndef DCACHE_WR_MACROS_SVH
`define DCACHE_WR_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// data bank geometry
////////////////////////////////////////////////////////////////////////////

// one cache line, 64 bytes.
`define DCACHE_LINE_BITS 512

// number of lines held in the bank.
`define DCACHE_DEPTH 16

// line index width, taken from address bits 9:6.
`define DCACHE_IDX_BITS 4

`endif
